/* logic/scr1_mem_pkg.sv */
`default_nettype none

package scr1_mem_pkg;

    // --------------------
    // Bus widths
    // --------------------
    localparam int MEM_AWIDTH = 32;
    localparam int MEM_DWIDTH = 32;

    // Request command
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    // Access width with one code for an illegal access
    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10,
        MEM_WIDTH_ERROR = 2'b11
    } mem_width_e;

    // Response code is non-idle for exactly one cycle
    typedef enum logic [1:0] {
        MEM_RESP_IDLE   = 2'b00,
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

    // 67-bit request payload
    typedef struct packed {
        mem_cmd_e               cmd;
        mem_width_e             width;
        logic [MEM_AWIDTH-1:0]  addr;
        logic [MEM_DWIDTH-1:0]  wdata;
    } mem_req_t;

    // 34-bit response payload
    typedef struct packed {
        mem_resp_e              resp;
        logic [MEM_DWIDTH-1:0]  rdata;
    } mem_rsp_t;

    // --------------------
    // Address map
    // --------------------
    localparam logic [MEM_AWIDTH-1:0] TCM_ADDR_MASK      = 32'hFFFF_F000;
    localparam logic [MEM_AWIDTH-1:0] TCM_ADDR_PATTERN   = 32'h0048_0000;
    localparam int                    TCM_WORDS          = 1024;
    localparam logic [MEM_AWIDTH-1:0] TIMER_ADDR_MASK    = 32'hFFFF_FFE0;
    localparam logic [MEM_AWIDTH-1:0] TIMER_ADDR_PATTERN = 32'h0049_0000;

    // Timer register offsets inside the 32-byte window
    localparam logic [4:0] TIMER_CTRL_OFS        = 5'h00;
    localparam logic [4:0] TIMER_MTIME_LO_OFS    = 5'h08;
    localparam logic [4:0] TIMER_MTIME_HI_OFS    = 5'h0C;
    localparam logic [4:0] TIMER_MTIMECMP_LO_OFS = 5'h10;
    localparam logic [4:0] TIMER_MTIMECMP_HI_OFS = 5'h14;

endpackage

`default_nettype wire

/* logic/scr1_dmem_router.sv */
`timescale 1ns/1ns
`default_nettype none

module scr1_dmem_router import scr1_mem_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_i,
    // Master side
    input  wire logic     dmem_req_i,
    input  wire mem_req_t dmem_req_data_i,
    output logic          dmem_req_ack_o,
    output mem_rsp_t      dmem_rsp_o,
    // TCM port that always accepts
    output logic          tcm_req_o,
    output mem_req_t      tcm_req_data_o,
    input  wire mem_rsp_t tcm_rsp_i,
    // Timer port that always accepts
    output logic          tmr_req_o,
    output mem_req_t      tmr_req_data_o,
    input  wire mem_rsp_t tmr_rsp_i,
    // External port with its own acknowledge
    output logic          ext_req_o,
    output mem_req_t      ext_req_data_o,
    input  wire logic     ext_req_ack_i,
    input  wire mem_rsp_t ext_rsp_i
);

    // Target of a request
    typedef enum logic [1:0] {
        TGT_EXT = 2'b00,
        TGT_TCM = 2'b01,
        TGT_TMR = 2'b10
    } tgt_e;

    tgt_e     tgt_sel;
    tgt_e     tgt_q;
    logic     pend_q;
    mem_rsp_t rsp_mux;
    logic     rsp_done;
    logic     slot_free;
    logic     req_acc;

    // --------------------
    // Address decode
    // --------------------
    always_comb begin
        if ((dmem_req_data_i.addr & TCM_ADDR_MASK) == TCM_ADDR_PATTERN) begin
            tgt_sel = TGT_TCM;
        end else if ((dmem_req_data_i.addr & TIMER_ADDR_MASK) == TIMER_ADDR_PATTERN) begin
            tgt_sel = TGT_TMR;
        end else begin
            // Everything else goes out
            tgt_sel = TGT_EXT;
        end
    end

    // --------------------
    // Response return
    // --------------------
    // Only the target of the pending request is listened to
    always_comb begin
        rsp_mux = '{resp: MEM_RESP_IDLE, rdata: '0};
        if (pend_q) begin
            unique case (tgt_q)
                TGT_TCM: rsp_mux = tcm_rsp_i;
                TGT_TMR: rsp_mux = tmr_rsp_i;
                default: rsp_mux = ext_rsp_i;
            endcase
        end
    end

    assign dmem_rsp_o = rsp_mux;
    assign rsp_done   = pend_q && (rsp_mux.resp != MEM_RESP_IDLE);

    // Room for a new request even in the cycle the old one completes
    assign slot_free = !pend_q || rsp_done;

    // --------------------
    // Request steering
    // --------------------
    // Ext port adds its own back-pressure
    assign dmem_req_ack_o = slot_free && ((tgt_sel != TGT_EXT) || ext_req_ack_i);
    assign req_acc        = dmem_req_i && dmem_req_ack_o;

    // Only the selected valid goes high
    assign tcm_req_o = dmem_req_i && slot_free && (tgt_sel == TGT_TCM);
    assign tmr_req_o = dmem_req_i && slot_free && (tgt_sel == TGT_TMR);
    assign ext_req_o = dmem_req_i && slot_free && (tgt_sel == TGT_EXT);

    // Payload fans out unchanged
    assign tcm_req_data_o = dmem_req_data_i;
    assign tmr_req_data_o = dmem_req_data_i;
    assign ext_req_data_o = dmem_req_data_i;

    // Pending flag and recorded target
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pend_q <= 1'b0;
            tgt_q  <= TGT_EXT;
        end else if (req_acc) begin
            pend_q <= 1'b1;
            tgt_q  <= tgt_sel;
        end else if (rsp_done) begin
            pend_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/scr1_tcm.sv */
`timescale 1ns/1ns
`default_nettype none

module scr1_tcm import scr1_mem_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_i,
    input  wire logic     req_i,
    input  wire mem_req_t req_data_i,
    output mem_rsp_t      rsp_o
);

    logic [MEM_DWIDTH-1:0] mem [TCM_WORDS];
    logic [9:0]            idx;
    logic [3:0]            be;
    logic                  acc_err;
    logic [MEM_DWIDTH-1:0] wdata_lane;
    logic                  wr_en;
    mem_resp_e             resp_q;
    logic [MEM_DWIDTH-1:0] rdata_q;

    // Word index
    assign idx = req_data_i.addr[11:2];

    // Byte enables and alignment check
    always_comb begin
        be      = 4'b0000;
        acc_err = 1'b0;
        unique case (req_data_i.width)
            MEM_WIDTH_BYTE: be = 4'b0001 << req_data_i.addr[1:0];
            MEM_WIDTH_HWORD: begin
                be      = 4'b0011 << {req_data_i.addr[1], 1'b0};
                acc_err = req_data_i.addr[0];
            end
            MEM_WIDTH_WORD: begin
                be      = 4'b1111;
                acc_err = |req_data_i.addr[1:0];
            end
            default: acc_err = 1'b1;
        endcase
    end

    // Low bits of wdata moved to the addressed lane
    assign wdata_lane = req_data_i.wdata << {req_data_i.addr[1:0], 3'b000};
    assign wr_en      = req_i && (req_data_i.cmd == MEM_CMD_WR) && !acc_err;

    // --------------------
    // Array and response
    // --------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[idx][b*8 +: 8] <= wdata_lane[b*8 +: 8];
                end
            end
        end
        // Full word read returns the value before any write this cycle
        if (req_i) begin
            rdata_q <= acc_err ? '0 : mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            resp_q <= MEM_RESP_IDLE;
        end else if (req_i) begin
            resp_q <= acc_err ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
        end else begin
            resp_q <= MEM_RESP_IDLE;
        end
    end

    assign rsp_o = '{resp: resp_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* logic/scr1_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module scr1_timer import scr1_mem_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_i,
    input  wire logic     req_i,
    input  wire mem_req_t req_data_i,
    output mem_rsp_t      rsp_o,
    output logic          timer_irq_o,
    output logic [63:0]   timer_val_o
);

    logic [4:0]            ofs;
    logic                  reg_hit;
    logic                  acc_ok;
    logic                  wr;
    logic [MEM_DWIDTH-1:0] rd_mux;
    logic                  en_q;
    logic [63:0]           mtime_q;
    logic [63:0]           mtimecmp_q;
    logic                  irq_q;
    mem_resp_e             resp_q;
    logic [MEM_DWIDTH-1:0] rdata_q;

    // --------------------
    // Register decode
    // --------------------
    assign ofs = req_data_i.addr[4:0];

    // Read mux that also flags mapped offsets
    always_comb begin
        reg_hit = 1'b1;
        rd_mux  = '0;
        unique case (ofs)
            TIMER_CTRL_OFS:        rd_mux = {31'b0, en_q};
            TIMER_MTIME_LO_OFS:    rd_mux = mtime_q[31:0];
            TIMER_MTIME_HI_OFS:    rd_mux = mtime_q[63:32];
            TIMER_MTIMECMP_LO_OFS: rd_mux = mtimecmp_q[31:0];
            TIMER_MTIMECMP_HI_OFS: rd_mux = mtimecmp_q[63:32];
            default:               reg_hit = 1'b0;
        endcase
    end

    // Word access to a mapped offset only
    assign acc_ok = reg_hit && (req_data_i.width == MEM_WIDTH_WORD);
    assign wr     = req_i && acc_ok && (req_data_i.cmd == MEM_CMD_WR);

    // --------------------
    // Timer registers
    // --------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            en_q       <= 1'b1;
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            irq_q      <= 1'b0;
        end else begin
            if (wr && (ofs == TIMER_CTRL_OFS)) begin
                en_q <= req_data_i.wdata[0];
            end
            // Write wins over counting
            if (wr && (ofs == TIMER_MTIME_LO_OFS)) begin
                mtime_q[31:0] <= req_data_i.wdata;
            end else if (wr && (ofs == TIMER_MTIME_HI_OFS)) begin
                mtime_q[63:32] <= req_data_i.wdata;
            end else if (en_q) begin
                mtime_q <= mtime_q + 64'd1;
            end
            if (wr && (ofs == TIMER_MTIMECMP_LO_OFS)) begin
                mtimecmp_q[31:0] <= req_data_i.wdata;
            end
            if (wr && (ofs == TIMER_MTIMECMP_HI_OFS)) begin
                mtimecmp_q[63:32] <= req_data_i.wdata;
            end
            // Level interrupt one cycle behind the compare
            irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    // Response one cycle after acceptance
    always_ff @(posedge clk) begin
        if (rst_i) begin
            resp_q <= MEM_RESP_IDLE;
        end else if (req_i) begin
            resp_q <= acc_ok ? MEM_RESP_RDY_OK : MEM_RESP_RDY_ER;
        end else begin
            resp_q <= MEM_RESP_IDLE;
        end
    end

    // Error reads give zero
    always_ff @(posedge clk) begin
        if (req_i) begin
            rdata_q <= acc_ok ? rd_mux : '0;
        end
    end

    assign rsp_o       = '{resp: resp_q, rdata: rdata_q};
    assign timer_irq_o = irq_q;
    assign timer_val_o = mtime_q;

endmodule

`default_nettype wire

/* logic/scr1_mem_cluster.sv */
`timescale 1ns/1ns
`default_nettype none

module scr1_mem_cluster import scr1_mem_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_i,
    // Master data port
    input  wire logic     dmem_req_i,
    input  wire mem_req_t dmem_req_data_i,
    output logic          dmem_req_ack_o,
    output mem_rsp_t      dmem_rsp_o,
    // External port
    output logic          ext_req_o,
    output mem_req_t      ext_req_data_o,
    input  wire logic     ext_req_ack_i,
    input  wire mem_rsp_t ext_rsp_i,
    // Timer outputs
    output logic          timer_irq_o,
    output logic [63:0]   timer_val_o
);

    // Router to TCM
    logic     tcm_req;
    mem_req_t tcm_req_data;
    mem_rsp_t tcm_rsp;

    // Router to timer
    logic     tmr_req;
    mem_req_t tmr_req_data;
    mem_rsp_t tmr_rsp;

    // --------------------
    // Data router
    // --------------------
    scr1_dmem_router i_dmem_router (
        .clk             (clk),
        .rst_i           (rst_i),
        .dmem_req_i      (dmem_req_i),
        .dmem_req_data_i (dmem_req_data_i),
        .dmem_req_ack_o  (dmem_req_ack_o),
        .dmem_rsp_o      (dmem_rsp_o),
        .tcm_req_o       (tcm_req),
        .tcm_req_data_o  (tcm_req_data),
        .tcm_rsp_i       (tcm_rsp),
        .tmr_req_o       (tmr_req),
        .tmr_req_data_o  (tmr_req_data),
        .tmr_rsp_i       (tmr_rsp),
        .ext_req_o       (ext_req_o),
        .ext_req_data_o  (ext_req_data_o),
        .ext_req_ack_i   (ext_req_ack_i),
        .ext_rsp_i       (ext_rsp_i)
    );

    // Tightly coupled memory
    scr1_tcm i_tcm (
        .clk        (clk),
        .rst_i      (rst_i),
        .req_i      (tcm_req),
        .req_data_i (tcm_req_data),
        .rsp_o      (tcm_rsp)
    );

    // Machine timer
    scr1_timer i_timer (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (tmr_req),
        .req_data_i  (tmr_req_data),
        .rsp_o       (tmr_rsp),
        .timer_irq_o (timer_irq_o),
        .timer_val_o (timer_val_o)
    );

endmodule

`default_nettype wire

/* tests/scr1_mem_cluster_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module scr1_mem_cluster_chk import scr1_mem_pkg::*; (
    input wire logic     clk,
    input wire logic     rst_i,
    input wire logic     req_i,
    input wire logic     ack_i,
    input wire mem_rsp_t rsp_i,
    input wire logic     tcm_req_i,
    input wire logic     tmr_req_i
);

    logic busy_q;

    // Outstanding request as seen on the master handshake
    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy_q <= 1'b0;
        end else if (req_i && ack_i) begin
            busy_q <= 1'b1;
        end else if (rsp_i.resp != MEM_RESP_IDLE) begin
            busy_q <= 1'b0;
        end
    end

    // Response only for an accepted request
    rsp_has_owner: assert property (@(posedge clk) disable iff (rst_i)
        (rsp_i.resp != MEM_RESP_IDLE) |-> busy_q)
        else $error("response without a pending request");

    // One request in flight
    ack_while_busy: assert property (@(posedge clk) disable iff (rst_i)
        (busy_q && (rsp_i.resp == MEM_RESP_IDLE)) |-> !ack_i)
        else $error("acknowledge while a response is pending");

    // Local targets answer in the next cycle
    local_latency: assert property (@(posedge clk) disable iff (rst_i)
        (tcm_req_i || tmr_req_i) |=> (rsp_i.resp != MEM_RESP_IDLE))
        else $error("local target did not answer in the next cycle");

endmodule

bind scr1_dmem_router scr1_mem_cluster_chk u_chk (
    .clk       (clk),
    .rst_i     (rst_i),
    .req_i     (dmem_req_i),
    .ack_i     (dmem_req_ack_o),
    .rsp_i     (dmem_rsp_o),
    .tcm_req_i (tcm_req_o),
    .tmr_req_i (tmr_req_o)
);

`default_nettype wire

/* tests/scr1_mem_cluster_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module scr1_mem_cluster_tb import scr1_mem_pkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int ACK_TIMEOUT = 50;
    localparam int RSP_TIMEOUT = 20;
    localparam int IRQ_TIMEOUT = 200;

    logic        clk;
    logic        rst_i;
    logic        dmem_req_i;
    mem_req_t    dmem_req_data_i;
    logic        dmem_req_ack_o;
    mem_rsp_t    dmem_rsp_o;
    logic        ext_req_o;
    mem_req_t    ext_req_data_o;
    logic        ext_req_ack_i;
    mem_rsp_t    ext_rsp_i;
    logic        timer_irq_o;
    logic [63:0] timer_val_o;

    int seed = 81;

    // Stimulus table with one entry per access
    string       tbl_name[$];
    mem_req_t    tbl_req[$];
    mem_resp_e   tbl_resp[$];
    logic [31:0] tbl_rdata[$];

    // Reference TCM contents
    logic [31:0] shadow [TCM_WORDS];

    // External memory model state
    logic [31:0] ext_mem [logic [31:0]];
    logic        ext_busy = 1'b0;
    int          ext_wait;
    mem_rsp_t    ext_pend;

    scr1_mem_cluster UUT (
        .clk             (clk),
        .rst_i           (rst_i),
        .dmem_req_i      (dmem_req_i),
        .dmem_req_data_i (dmem_req_data_i),
        .dmem_req_ack_o  (dmem_req_ack_o),
        .dmem_rsp_o      (dmem_rsp_o),
        .ext_req_o       (ext_req_o),
        .ext_req_data_o  (ext_req_data_o),
        .ext_req_ack_i   (ext_req_ack_i),
        .ext_rsp_i       (ext_rsp_i),
        .timer_irq_o     (timer_irq_o),
        .timer_val_o     (timer_val_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------
    // Error reporting
    // --------------------
    task automatic stop_run();
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(string test, string exp, string act);
        $display("** Error: %s expected %s actual %s", test, exp, act);
        stop_run();
    endtask

    task automatic report_failure(string what);
        $display("** Error: %s", what);
        stop_run();
    endtask

    // --------------------
    // Reference models
    // --------------------
    function automatic bit is_local(logic [31:0] addr);
        return ((addr & TCM_ADDR_MASK) == TCM_ADDR_PATTERN) ||
               ((addr & TIMER_ADDR_MASK) == TIMER_ADDR_PATTERN);
    endfunction

    // Fill for unwritten external words depends on every address bit
    function automatic logic [31:0] ext_fill(logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5A5A_5A5A;
    endfunction

    function automatic mem_rsp_t ext_serve(mem_req_t req);
        mem_rsp_t rsp;
        rsp.resp  = MEM_RESP_RDY_OK;
        rsp.rdata = '0;
        if (req.width == MEM_WIDTH_ERROR) begin
            rsp.resp = MEM_RESP_RDY_ER;
        end else if (req.cmd == MEM_CMD_WR) begin
            ext_mem[req.addr] = req.wdata;
        end else if (ext_mem.exists(req.addr)) begin
            rsp.rdata = ext_mem[req.addr];
        end else begin
            rsp.rdata = ext_fill(req.addr);
        end
        return rsp;
    endfunction

    // External port stalls at random and replies 1 to 3 cycles after acceptance
    initial begin
        ext_req_ack_i = 1'b0;
        ext_rsp_i     = '0;
        forever begin
            @(negedge clk);
            ext_rsp_i = '0;
            if (ext_busy) begin
                ext_wait--;
                if (ext_wait == 0) begin
                    ext_rsp_i = ext_pend;
                    ext_busy  = 1'b0;
                end
            end
            ext_req_ack_i = !ext_busy && ($random(seed) % 2 != 0);
            // Accepted on the coming rising edge
            #(CLK_PERIOD / 4);
            if (ext_req_o && ext_req_ack_i) begin
                ext_pend = ext_serve(ext_req_data_o);
                ext_wait = 1 + $unsigned($random(seed)) % 3;
                ext_busy = 1'b1;
            end
        end
    end

    // --------------------
    // Table building
    // --------------------
    task automatic add_row(string name, mem_cmd_e cmd, mem_width_e width, logic [31:0] addr,
                           logic [31:0] wdata, mem_resp_e resp, logic [31:0] rdata);
        mem_req_t req;
        req = '{cmd: cmd, width: width, addr: addr, wdata: wdata};
        tbl_name.push_back(name);
        tbl_req.push_back(req);
        tbl_resp.push_back(resp);
        tbl_rdata.push_back(rdata);
    endtask

    // Expected TCM result with the shadow updated by the byte-enable rule
    task automatic add_tcm_row(string name, mem_cmd_e cmd, mem_width_e width,
                               logic [31:0] addr, logic [31:0] wdata);
        logic [9:0]  idx;
        logic        bad;
        logic [31:0] rdata;
        idx   = addr[11:2];
        bad   = (width == MEM_WIDTH_ERROR) || ((width == MEM_WIDTH_HWORD) && addr[0]) ||
                ((width == MEM_WIDTH_WORD) && (addr[1:0] != 2'b00));
        rdata = '0;
        if (!bad && (cmd == MEM_CMD_RD)) begin
            rdata = shadow[idx];
        end
        if (!bad && (cmd == MEM_CMD_WR)) begin
            case (width)
                MEM_WIDTH_BYTE:  shadow[idx][addr[1:0]*8 +: 8] = wdata[7:0];
                MEM_WIDTH_HWORD: shadow[idx][addr[1]*16 +: 16] = wdata[15:0];
                default:         shadow[idx] = wdata;
            endcase
        end
        add_row(name, cmd, width, addr, wdata,
                bad ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK, rdata);
    endtask

    task automatic build_table();
        // TCM lanes
        add_tcm_row("tcm word wr", MEM_CMD_WR, MEM_WIDTH_WORD, 32'h0048_0010, 32'h1122_3344);
        add_tcm_row("tcm byte wr", MEM_CMD_WR, MEM_WIDTH_BYTE, 32'h0048_0011, 32'h0000_00AA);
        add_tcm_row("tcm hword wr", MEM_CMD_WR, MEM_WIDTH_HWORD, 32'h0048_0012, 32'h0000_BEEF);
        add_tcm_row("tcm word rd", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0048_0010, 32'h0);
        add_tcm_row("tcm top wr", MEM_CMD_WR, MEM_WIDTH_WORD, 32'h0048_0FFC, 32'hDEAD_BEEF);
        add_tcm_row("tcm byte3 wr", MEM_CMD_WR, MEM_WIDTH_BYTE, 32'h0048_0FFF, 32'h0000_0055);
        add_tcm_row("tcm byte rd", MEM_CMD_RD, MEM_WIDTH_BYTE, 32'h0048_0FFD, 32'h0);
        add_tcm_row("tcm hword0 wr", MEM_CMD_WR, MEM_WIDTH_HWORD, 32'h0048_0010, 32'hFFFF_7766);
        add_tcm_row("tcm word rd2", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0048_0010, 32'h0);
        // Misaligned and illegal widths
        add_tcm_row("tcm hword mis", MEM_CMD_WR, MEM_WIDTH_HWORD, 32'h0048_0011, 32'h0000_9999);
        add_tcm_row("tcm word mis", MEM_CMD_WR, MEM_WIDTH_WORD, 32'h0048_0012, 32'h9999_9999);
        add_tcm_row("tcm width err", MEM_CMD_WR, MEM_WIDTH_ERROR, 32'h0048_0010, 32'h9999_9999);
        add_tcm_row("tcm rd mis", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0048_0013, 32'h0);
        add_tcm_row("tcm unchanged", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0048_0010, 32'h0);
        // External port including addresses just past both windows
        add_row("ext word wr", MEM_CMD_WR, MEM_WIDTH_WORD, 32'h0010_0000, 32'hCAFE_F00D,
                MEM_RESP_RDY_OK, 32'h0);
        add_row("ext word rd", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0010_0000, 32'h0,
                MEM_RESP_RDY_OK, 32'hCAFE_F00D);
        add_row("ext fill rd", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0020_0104, 32'h0,
                MEM_RESP_RDY_OK, ext_fill(32'h0020_0104));
        add_row("ext hword wr", MEM_CMD_WR, MEM_WIDTH_HWORD, 32'h3000_0002, 32'h0000_1357,
                MEM_RESP_RDY_OK, 32'h0);
        add_row("ext past tcm", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0048_1000, 32'h0,
                MEM_RESP_RDY_OK, ext_fill(32'h0048_1000));
        add_row("ext past timer", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0049_0020, 32'h0,
                MEM_RESP_RDY_OK, ext_fill(32'h0049_0020));
        add_row("ext error", MEM_CMD_RD, MEM_WIDTH_ERROR, 32'h0010_0000, 32'h0,
                MEM_RESP_RDY_ER, 32'h0);
        // Timer registers with the counter stopped
        add_row("tmr stop", MEM_CMD_WR, MEM_WIDTH_WORD, 32'h0049_0000, 32'h0,
                MEM_RESP_RDY_OK, 32'h0);
        add_row("tmr lo wr", MEM_CMD_WR, MEM_WIDTH_WORD, 32'h0049_0008, 32'h1234_5678,
                MEM_RESP_RDY_OK, 32'h0);
        add_row("tmr hi wr", MEM_CMD_WR, MEM_WIDTH_WORD, 32'h0049_000C, 32'h0000_00AB,
                MEM_RESP_RDY_OK, 32'h0);
        add_row("tmr lo rd", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0049_0008, 32'h0,
                MEM_RESP_RDY_OK, 32'h1234_5678);
        add_row("tmr hi rd", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0049_000C, 32'h0,
                MEM_RESP_RDY_OK, 32'h0000_00AB);
        add_row("tmr ctrl rd", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0049_0000, 32'h0,
                MEM_RESP_RDY_OK, 32'h0);
        add_row("tmr cmp hi rd", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0049_0014, 32'h0,
                MEM_RESP_RDY_OK, 32'hFFFF_FFFF);
        add_row("tmr unmapped rd", MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0049_0004, 32'h0,
                MEM_RESP_RDY_ER, 32'h0);
        add_row("tmr unmapped wr", MEM_CMD_WR, MEM_WIDTH_WORD, 32'h0049_0018, 32'h1,
                MEM_RESP_RDY_ER, 32'h0);
        add_row("tmr hword rd", MEM_CMD_RD, MEM_WIDTH_HWORD, 32'h0049_0008, 32'h0,
                MEM_RESP_RDY_ER, 32'h0);
    endtask

    // --------------------
    // Bus access
    // --------------------
    task automatic check_ext_port(mem_req_t req);
        if (is_local(req.addr)) begin
            assert (!ext_req_o) else report_failure("external request for a local address");
        end else begin
            assert (ext_req_o && (ext_req_data_o == req))
                else report_mismatch("ext port request", $sformatf("%h", req),
                                     $sformatf("%h", ext_req_data_o));
        end
    endtask

    // Sampling a quarter period after the falling edge
    task automatic issue_request(input mem_req_t req, output mem_rsp_t rsp, output int cycles);
        int wait_cnt;
        @(negedge clk);
        dmem_req_i      = 1'b1;
        dmem_req_data_i = req;
        #(CLK_PERIOD / 4);
        wait_cnt = 0;
        while (!dmem_req_ack_o) begin
            check_ext_port(req);
            wait_cnt++;
            if (wait_cnt > ACK_TIMEOUT) begin
                report_failure("request never acknowledged");
            end
            @(negedge clk);
            #(CLK_PERIOD / 4);
        end
        check_ext_port(req);
        // Stalled external port must hold the acknowledge low
        if (!is_local(req.addr)) begin
            assert (ext_req_ack_i) else report_mismatch("ack under stall", "0", "1");
        end
        @(negedge clk);
        dmem_req_i = 1'b0;
        #(CLK_PERIOD / 4);
        cycles = 1;
        while (dmem_rsp_o.resp == MEM_RESP_IDLE) begin
            if (cycles > RSP_TIMEOUT) begin
                report_failure("no response after acceptance");
            end
            cycles++;
            @(negedge clk);
            #(CLK_PERIOD / 4);
        end
        rsp = dmem_rsp_o;
    endtask

    task automatic timer_access(mem_cmd_e cmd, logic [4:0] ofs, logic [31:0] wdata,
                                output logic [31:0] rdata);
        mem_req_t req;
        mem_rsp_t rsp;
        int       cycles;
        req = '{cmd: cmd, width: MEM_WIDTH_WORD, addr: TIMER_ADDR_PATTERN | {27'b0, ofs},
                wdata: wdata};
        issue_request(req, rsp, cycles);
        assert (rsp.resp == MEM_RESP_RDY_OK)
            else report_mismatch("timer access", "RDY_OK", rsp.resp.name());
        rdata = rsp.rdata;
    endtask

    task automatic wait_for_irq(logic level);
        int cnt;
        cnt = 0;
        while (timer_irq_o != level) begin
            cnt++;
            if (cnt > IRQ_TIMEOUT) begin
                report_failure($sformatf("timer_irq_o never went to %0d", level));
            end
            @(negedge clk);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        mem_rsp_t    rsp;
        int          cycles;
        logic [31:0] rd;
        logic [31:0] lo;
        logic [31:0] t0;
        logic [31:0] t1;
        rst_i           = 1'b1;
        dmem_req_i      = 1'b0;
        dmem_req_data_i = '0;
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        #(CLK_PERIOD / 4);

        // Idle after reset
        assert (dmem_rsp_o.resp == MEM_RESP_IDLE)
            else report_mismatch("reset rsp", "IDLE", dmem_rsp_o.resp.name());
        assert (!ext_req_o) else report_mismatch("reset ext_req_o", "0", "1");
        assert (!timer_irq_o) else report_mismatch("reset timer_irq_o", "0", "1");

        for (int i = 0; i < tbl_name.size(); i++) begin
            issue_request(tbl_req[i], rsp, cycles);
            assert (rsp.resp == tbl_resp[i])
                else report_mismatch(tbl_name[i], tbl_resp[i].name(), rsp.resp.name());
            if (tbl_req[i].cmd == MEM_CMD_RD) begin
                assert (rsp.rdata == tbl_rdata[i])
                    else report_mismatch(tbl_name[i], $sformatf("%h", tbl_rdata[i]),
                                         $sformatf("%h", rsp.rdata));
            end
            // Local targets answer in the next cycle and ext within the model's delay
            assert (is_local(tbl_req[i].addr) ? (cycles == 1) : (cycles <= 3))
                else report_mismatch({tbl_name[i], " latency"},
                                     is_local(tbl_req[i].addr) ? "1" : "1..3",
                                     $sformatf("%0d", cycles));
        end

        // Stopped counter holds the written value
        assert (timer_val_o == 64'h0000_00AB_1234_5678)
            else report_mismatch("timer_val_o", "000000ab12345678",
                                 $sformatf("%h", timer_val_o));
        repeat (5) @(negedge clk);
        assert (timer_val_o == 64'h0000_00AB_1234_5678)
            else report_mismatch("counter stopped", "000000ab12345678",
                                 $sformatf("%h", timer_val_o));

        // Compare just ahead of mtime
        timer_access(MEM_CMD_WR, TIMER_CTRL_OFS, 32'h1, rd);
        timer_access(MEM_CMD_RD, TIMER_MTIME_LO_OFS, 32'h0, lo);
        timer_access(MEM_CMD_WR, TIMER_MTIMECMP_LO_OFS, lo + 32'd40, rd);
        timer_access(MEM_CMD_WR, TIMER_MTIMECMP_HI_OFS, 32'h0000_00AB, rd);
        assert (!timer_irq_o) else report_mismatch("irq before compare", "0", "1");
        wait_for_irq(1'b1);
        timer_access(MEM_CMD_WR, TIMER_MTIMECMP_HI_OFS, 32'hFFFF_FFFF, rd);
        wait_for_irq(1'b0);

        // Running counter
        timer_access(MEM_CMD_RD, TIMER_MTIME_LO_OFS, 32'h0, t0);
        repeat (4) @(negedge clk);
        timer_access(MEM_CMD_RD, TIMER_MTIME_LO_OFS, 32'h0, t1);
        assert (t1 > t0)
            else report_mismatch("mtime increases", $sformatf("> %h", t0), $sformatf("%h", t1));

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
logic/scr1_mem_pkg.sv
logic/scr1_dmem_router.sv
logic/scr1_tcm.sv
logic/scr1_timer.sv
logic/scr1_mem_cluster.sv
tests/scr1_mem_cluster_chk.sv
tests/scr1_mem_cluster_tb.sv

/* Makefile */
# Verilator build and run of the memory cluster testbench

VERILATOR ?= verilator
TOP       ?= scr1_mem_cluster_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
